/* hdl/mipsPkg.sv */
// ============================================================
// shared types and encodings of the multicycle core
// import with mipsPkg::* in the module header
// ============================================================
`default_nettype none

package mipsPkg;

	typedef logic [31:0] tWord;     // one data or address word
	typedef logic [4:0]  tRegAddr;  // register index
	typedef logic [1:0]  tLane;     // byte offset inside a word
	typedef logic [3:0]  tByteEn;   // one enable per byte

	// major opcodes kept by the core
	typedef enum logic [5:0] {
		opRtype = 6'h00, opJ    = 6'h02, opJal  = 6'h03, opBeq  = 6'h04,
		opBne   = 6'h05, opAddiu = 6'h09, opSlti = 6'h0a, opAndi = 6'h0c,
		opOri   = 6'h0d, opLui  = 6'h0f, opLb   = 6'h20, opLh   = 6'h21,
		opLw    = 6'h23, opLbu  = 6'h24, opLhu  = 6'h25, opSb   = 6'h28,
		opSh    = 6'h29, opSw   = 6'h2b
	} tOpcode;

	typedef enum logic [5:0] {
		fcSll = 6'h00, fcSrl = 6'h02, fcJr  = 6'h08, fcAddu = 6'h21, fcSubu = 6'h23,
		fcAnd = 6'h24, fcOr  = 6'h25, fcXor = 6'h26, fcSlt  = 6'h2a
	} tFunct;

	typedef enum logic [1:0] {aluAdd, aluSub, aluFunct, aluImm} tAluOp;
	typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} tMemSize;

	typedef enum logic [3:0] {
		stFetch, stDecode, stExecR, stExecI, stAddrCalc, stMemRead,
		stMemWrite, stLoadWb, stAluWb, stBranch, stJump, stJumpReg
	} tFsmState;

	// ALU operand B select
	localparam logic [2:0] srcBReg = 3'd0, srcBFour = 3'd1, srcBSignImm = 3'd2;
	localparam logic [2:0] srcBBranchOff = 3'd3, srcBZeroImm = 3'd4;
	// next PC select
	localparam logic [1:0] pcSrcAlu = 2'd0, pcSrcAluOut = 2'd1, pcSrcJump = 2'd2;
	localparam logic [1:0] pcSrcRegA = 2'd3;

	typedef struct packed {
		tOpcode opcode;
		tRegAddr rt;
		tFunct funct;
		logic [4:0] shamt;
	} tDecode;

	typedef struct packed {
		logic irWrite, pcWrite, pcWriteBeq, pcWriteBne;
		logic iorD, memRead, memWrite, regWrite;
		logic regDst, memToReg, linkWrite, laneCapture;
		logic aluSrcA;        // 0 PC, 1 register A
		logic [2:0] aluSrcB;
		logic [1:0] pcSource;
		tAluOp aluOp;
		tMemSize memSize;
		logic loadSigned;
	} tCtrl;

	typedef struct packed {
		tWord addr;
		tWord wdata;
		tByteEn byteEn;
		logic we;
		logic re;
	} tMemReq;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
// ============================================================
// 32 x 32 register file, two async reads, one sync write
// register 0 reads zero and ignores writes
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input wire iCLK,
	input wire iRST,
	input wire tRegAddr readAddr1,
	input wire tRegAddr readAddr2,
	input wire tRegAddr writeAddr,
	input wire tWord writeData,
	input wire writeEnable,
	output tWord readData1,
	output tWord readData2
);

	tWord regs [32];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && (writeAddr != 5'd0))  // r0 stays zero
			regs[writeAddr] <= writeData;
	end

	assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

/* hdl/aluUnit.sv */
// ============================================================
// integer ALU with its function decode
// the FSM asks for a class, funct or opcode pick the operation
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aluUnit import mipsPkg::*; (
	input wire tAluOp aluOp,
	input wire tDecode decode,
	input wire tWord a,
	input wire tWord b,
	output tWord result,
	output logic zero
);

	typedef enum logic [3:0] {
		doAdd, doSub, doAnd, doOr, doXor, doSlt, doSll, doSrl, doLui
	} tAluFn;

	tAluFn fn;

	// class to concrete operation
	always_comb
	begin
		fn = doAdd;
		case (aluOp)
			aluSub: fn = doSub;
			aluFunct:
			begin
				case (decode.funct)
					fcSubu: fn = doSub;
					fcAnd: fn = doAnd;
					fcOr: fn = doOr;
					fcXor: fn = doXor;
					fcSlt: fn = doSlt;
					fcSll: fn = doSll;
					fcSrl: fn = doSrl;
					default: fn = doAdd;  // addu and anything else
				endcase
			end
			aluImm:
			begin
				case (decode.opcode)
					opAndi: fn = doAnd;
					opOri: fn = doOr;
					opSlti: fn = doSlt;
					opLui: fn = doLui;
					default: fn = doAdd;  // addiu
				endcase
			end
			default: fn = doAdd;
		endcase
	end

	always_comb
	begin
		case (fn)
			doSub: result = a - b;
			doAnd: result = a & b;
			doOr: result = a | b;
			doXor: result = a ^ b;
			doSlt: result = {31'b0, $signed(a) < $signed(b)};  // signed compare
			doSll: result = b << decode.shamt;
			doSrl: result = b >> decode.shamt;  // logical, zero fill
			doLui: result = {b[15:0], 16'b0};
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/memLane.sv */
// ============================================================
// byte lane handling for loads and stores, little endian
// stores spread the data and set byte enables
// loads pick the addressed bytes and extend them
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module memLane import mipsPkg::*; (
	input wire tMemSize size,
	input wire loadSigned,
	input wire tLane storeLane,
	input wire tWord storeData,
	output tWord storeWord,
	output tByteEn byteEn,
	input wire tLane loadLane,
	input wire tWord loadWord,
	output tWord loadData
);

	tWord byteShifted;  // addressed byte moved to bits 7..0
	tWord halfShifted;  // addressed half moved to bits 15..0

	// store side, same bytes in every lane, enables pick the target
	always_comb
	begin
		case (size)
			sizeByte:
			begin
				storeWord = {4{storeData[7:0]}};
				byteEn = 4'b0001 << storeLane;
			end
			sizeHalf:
			begin
				storeWord = {2{storeData[15:0]}};
				byteEn = storeLane[1] ? 4'b1100 : 4'b0011;  // upper or lower half
			end
			default:
			begin
				storeWord = storeData;
				byteEn = 4'b1111;
			end
		endcase
	end

	// load side
	assign byteShifted = loadWord >> {loadLane, 3'b000};
	assign halfShifted = loadWord >> {loadLane[1], 4'b0000};

	always_comb
	begin
		case (size)
			sizeByte: loadData = {{24{loadSigned & byteShifted[7]}}, byteShifted[7:0]};
			sizeHalf: loadData = {{16{loadSigned & halfShifted[15]}}, halfShifted[15:0]};
			default: loadData = loadWord;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/dataPath.sv */
// ============================================================
// datapath of the multicycle core
// PC, IR, A, B, MDR, ALUOut and the operand muxes
// the control bundle steers every phase
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module dataPath import mipsPkg::*; #(
	parameter tWord bootAddr = 32'h0040_0000
) (
	input wire iCLK,
	input wire iRST,
	input wire tCtrl ctrl,
	output tDecode decode,
	output tMemReq memReq,
	input wire tWord memRdata,
	output tWord pc
);

	tWord instrReg, regA, regB, memData, aluOut;
	tLane laneReg;                       // byte offset of the pending load
	tWord readData1, readData2;
	tWord aluA, aluB, aluResult;
	logic aluZero;
	tWord signImm, zeroImm, branchOff, jumpTarget;
	tWord nextPc, writeData, loadData;
	tRegAddr rs, rd, writeAddr;
	logic pcEnable;

	assign rs = instrReg[25:21];
	assign rd = instrReg[15:11];
	assign signImm = {{16{instrReg[15]}}, instrReg[15:0]};
	assign zeroImm = {16'b0, instrReg[15:0]};
	assign branchOff = {{14{instrReg[15]}}, instrReg[15:0], 2'b00};  // words to bytes
	assign jumpTarget = {pc[31:28], instrReg[25:0], 2'b00};

	always_comb
	begin
		decode.opcode = tOpcode'(instrReg[31:26]);  // unlisted codes kept as is
		decode.rt = instrReg[20:16];
		decode.funct = tFunct'(instrReg[5:0]);
		decode.shamt = instrReg[10:6];
	end

	// ALU operands
	assign aluA = ctrl.aluSrcA ? regA : pc;
	always_comb
	begin
		case (ctrl.aluSrcB)
			srcBReg: aluB = regB;
			srcBFour: aluB = 32'd4;
			srcBSignImm: aluB = signImm;
			srcBBranchOff: aluB = branchOff;
			srcBZeroImm: aluB = zeroImm;
			default: aluB = '0;
		endcase
	end

	always_comb
	begin
		case (ctrl.pcSource)
			pcSrcAlu: nextPc = aluResult;     // sequential
			pcSrcAluOut: nextPc = aluOut;     // branch target from decode
			pcSrcJump: nextPc = jumpTarget;
			default: nextPc = regA;           // jr
		endcase
	end

	// branch decision off the ALU compare
	assign pcEnable = ctrl.pcWrite | (ctrl.pcWriteBeq & aluZero) | (ctrl.pcWriteBne & ~aluZero);

	// link path forces r31 and the incremented PC
	assign writeAddr = ctrl.linkWrite ? 5'd31 : (ctrl.regDst ? rd : decode.rt);
	assign writeData = ctrl.linkWrite ? pc : (ctrl.memToReg ? loadData : aluOut);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pc <= bootAddr;
			instrReg <= '0;
			regA <= '0;
			regB <= '0;
			memData <= '0;
			aluOut <= '0;
			laneReg <= '0;
		end
		else
		begin
			regA <= readData1;
			regB <= readData2;
			memData <= memRdata;
			aluOut <= aluResult;
			if (pcEnable)
				pc <= nextPc;
			if (ctrl.irWrite)
				instrReg <= memRdata;
			if (ctrl.laneCapture)
				laneReg <= aluOut[1:0];
		end
	end

	assign memReq.addr = ctrl.iorD ? aluOut : pc;  // data access or fetch
	assign memReq.we = ctrl.memWrite;
	assign memReq.re = ctrl.memRead;

	regFile rf0 (
		.iCLK (iCLK), .iRST (iRST),
		.readAddr1 (rs), .readAddr2 (decode.rt),
		.writeAddr (writeAddr), .writeData (writeData), .writeEnable (ctrl.regWrite),
		.readData1 (readData1), .readData2 (readData2)
	);

	aluUnit alu0 (
		.aluOp (ctrl.aluOp), .decode (decode),
		.a (aluA), .b (aluB), .result (aluResult), .zero (aluZero)
	);

	memLane lane0 (
		.size (ctrl.memSize), .loadSigned (ctrl.loadSigned),
		.storeLane (aluOut[1:0]), .storeData (regB),
		.storeWord (memReq.wdata), .byteEn (memReq.byteEn),
		.loadLane (laneReg), .loadWord (memData), .loadData (loadData)
	);

endmodule

`default_nettype wire

/* hdl/controlFsm.sv */
// ============================================================
// control FSM of the multicycle core
// one state per clock, the control bundle follows the state
// and the decoded opcode combinationally
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module controlFsm import mipsPkg::*; (
	input wire iCLK,
	input wire iRST,
	input wire tDecode decode,
	output tCtrl ctrl
);

	tFsmState state;
	tFsmState nextState;
	logic isStore;

	// access width from the load or store opcode
	function automatic tMemSize accessSize(input tOpcode op);
		tMemSize size;
		case (op)
			opLb, opLbu, opSb: size = sizeByte;
			opLh, opLhu, opSh: size = sizeHalf;
			default: size = sizeWord;
		endcase
		return size;
	endfunction

	assign isStore = decode.opcode inside {opSb, opSh, opSw};

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = stFetch;  // most paths end here
		case (state)
			stFetch: nextState = stDecode;
			stDecode:
			begin
				case (decode.opcode)
					opRtype: nextState = (decode.funct == fcJr) ? stJumpReg : stExecR;
					opAddiu, opAndi, opOri, opSlti, opLui: nextState = stExecI;
					opLw, opLh, opLhu, opLb, opLbu, opSw, opSh, opSb: nextState = stAddrCalc;
					opBeq, opBne: nextState = stBranch;
					opJ, opJal: nextState = stJump;
					default: nextState = stFetch;  // unknown opcode, only PC+4 happened
				endcase
			end
			stExecR, stExecI: nextState = stAluWb;
			stAddrCalc: nextState = isStore ? stMemWrite : stMemRead;
			stMemRead: nextState = stLoadWb;
			default: nextState = stFetch;
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		case (state)
			stFetch:
			begin
				ctrl.memRead = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcB = srcBFour;     // PC + 4
				ctrl.pcSource = pcSrcAlu;
				ctrl.pcWrite = 1'b1;
			end
			stDecode: ctrl.aluSrcB = srcBBranchOff;  // branch target into ALUOut
			stExecR:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBReg;
				ctrl.aluOp = aluFunct;
			end
			stExecI:
			begin
				ctrl.aluSrcA = 1'b1;
				// logical ops and lui take the unsigned immediate
				if (decode.opcode inside {opAndi, opOri, opLui})
					ctrl.aluSrcB = srcBZeroImm;
				else
					ctrl.aluSrcB = srcBSignImm;
				ctrl.aluOp = aluImm;
			end
			stAddrCalc:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBSignImm;  // base + offset
				ctrl.aluOp = aluAdd;
			end
			stMemRead:
			begin
				ctrl.iorD = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.laneCapture = 1'b1;  // keep offset for writeback
				ctrl.memSize = accessSize(decode.opcode);
			end
			stMemWrite:
			begin
				ctrl.iorD = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memSize = accessSize(decode.opcode);
			end
			stLoadWb:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memSize = accessSize(decode.opcode);
				ctrl.loadSigned = decode.opcode inside {opLb, opLh};
			end
			stAluWb:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = (decode.opcode == opRtype);  // rd for R-type, rt otherwise
			end
			stBranch:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBReg;
				ctrl.aluOp = aluSub;  // compare by subtraction
				ctrl.pcSource = pcSrcAluOut;
				ctrl.pcWriteBeq = (decode.opcode == opBeq);
				ctrl.pcWriteBne = (decode.opcode == opBne);
			end
			stJump:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = pcSrcJump;
				ctrl.regWrite = (decode.opcode == opJal);
				ctrl.linkWrite = (decode.opcode == opJal);  // r31 gets PC+4
			end
			stJumpReg:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = pcSrcRegA;
			end
			default: ;
		endcase
		// bus stays quiet while reset is held
		if (iRST)
		begin
			ctrl.memRead = 1'b0;
			ctrl.memWrite = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/multiCycleCore.sv */
// ============================================================
// multicycle MIPS-style integer core, top level
// one phase per clock over a single shared memory bus
// memory answers reads combinationally, writes at the edge
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module multiCycleCore import mipsPkg::*; #(
	parameter tWord bootAddr = 32'h0040_0000  // first fetch after reset
) (
	input wire iCLK,
	input wire iRST,
	output tMemReq memReq,
	input wire tWord memRdata,
	output tWord pc
);

	tCtrl ctrl;      // control bundle for the current phase
	tDecode decode;  // IR fields back to the FSM

	// sequencer
	controlFsm fsm0 (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.decode (decode),
		.ctrl   (ctrl)
	);

	// registers, ALU and byte lanes
	dataPath #(
		.bootAddr (bootAddr)
	) dp0 (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.ctrl     (ctrl),
		.decode   (decode),
		.memReq   (memReq),
		.memRdata (memRdata),
		.pc       (pc)
	);

endmodule

`default_nettype wire

/* bench/coreTb.sv */
// ============================================================
// testbench of the multicycle core
// preloads a hand-encoded program and random data, models
// the memory bus and checks every store against a reference
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module coreTb import mipsPkg::*;;

	localparam tWord bootAddr = 32'h0000_0040;  // nonzero on purpose
	localparam tWord subAddr = 32'h0000_01e0;   // jal target, below data

	typedef struct packed {
		tWord addr;       // byte address as issued by the core
		tByteEn be;
		tWord data;       // whole word after the store
		logic [2:0] test;
	} tExpect;

	logic iCLK = 1'b0;
	logic iRST;
	tMemReq memReq;
	tWord memRdata;
	tWord pc;

	tWord mem [0:255];     // 1 KB, word addressed
	tWord refMem [0:255];  // reference image of the same memory
	tExpect expectQ [$];   // stores in program order
	tWord emitAddr, haltAddr;
	int instrCount;
	int errCount [1:6];
	bit reported [1:6];
	string testName [1:6];
	int passCount, failCount, totalErrors;
	bit bootChecked;

	always #5 iCLK = ~iCLK;

	multiCycleCore #(.bootAddr(bootAddr)) dut0 (
		.iCLK (iCLK), .iRST (iRST), .memReq (memReq), .memRdata (memRdata), .pc (pc)
	);

	assign memRdata = mem[memReq.addr[9:2]];  // answers in the same cycle

	// instruction encoders
	function automatic tWord encR(tFunct fn, tRegAddr rs, tRegAddr rt, tRegAddr rd,
		logic [4:0] sh);
		return {opRtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic tWord encI(tOpcode op, tRegAddr rs, tRegAddr rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic tWord encJ(tOpcode op, tWord target);
		return {op, target[27:2]};
	endfunction

	task automatic emitInstr(tWord instr);
		mem[emitAddr[9:2]] = instr;
		emitAddr += 4;
		instrCount++;
	endtask

	// merge into the reference image and queue the store
	task automatic expectStore(int test, tWord addr, tByteEn be, tWord laneVal);
		tWord word;
		word = refMem[addr[9:2]];
		for (int i = 0; i < 4; i++)
			if (be[i])
				word[8*i +: 8] = laneVal[8*i +: 8];
		refMem[addr[9:2]] = word;
		expectQ.push_back('{addr: addr, be: be, data: word, test: test[2:0]});
	endtask

	task automatic storeReg(tRegAddr rt, tWord addr, int test, tWord value);
		emitInstr(encI(opSw, 0, rt, addr[15:0]));
		expectStore(test, addr, 4'hf, value);
	endtask

	task automatic aluCase(tWord instr, tWord value, tWord addr);
		emitInstr(instr);
		storeReg(3, addr, 2, value);  // every op result goes through r3
	endtask

	task automatic loadCase(tOpcode op, tWord addr, tWord value, tWord dst);
		emitInstr(encI(op, 0, 4, addr[15:0]));
		storeReg(4, dst, 4, value);
	endtask

	task automatic buildProgram();
		tWord a, b, w, jalAddr;
		logic [7:0] bt;
		logic [15:0] hf;
		integer seed;
		seed = 32;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hdead_0000 | tWord'(i << 2);  // unused words carry their address
		for (int i = 0; i < 8; i++)
			mem[128 + i] = $random(seed);  // data area at 0x200
		// force both signs per lane and make the operands differ
		// a positive and b negative for signed compare and logical shift
		mem[128] = (mem[128] | 32'h0080_0080) & ~32'h8000_8010;
		mem[129] = (mem[129] | 32'h8000_0010) & ~32'h0000_8000;
		for (int i = 0; i < 256; i++)
			refMem[i] = mem[i];
		a = mem[128];
		b = mem[129];
		emitAddr = bootAddr;
		instrCount = 0;
		// ALU results
		emitInstr(encI(opLw, 0, 1, 16'h0200));
		emitInstr(encI(opLw, 0, 2, 16'h0204));
		aluCase(encR(fcAddu, 1, 2, 3, 0), a + b, 32'h300);
		aluCase(encR(fcSubu, 1, 2, 3, 0), a - b, 32'h304);
		aluCase(encR(fcAnd, 1, 2, 3, 0), a & b, 32'h308);
		aluCase(encR(fcOr, 1, 2, 3, 0), a | b, 32'h30c);
		aluCase(encR(fcXor, 1, 2, 3, 0), a ^ b, 32'h310);
		aluCase(encR(fcSlt, 1, 2, 3, 0), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, 32'h314);
		aluCase(encR(fcSlt, 2, 1, 3, 0), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, 32'h318);
		aluCase(encR(fcSll, 0, 2, 3, 5), b << 5, 32'h31c);
		aluCase(encR(fcSrl, 0, 2, 3, 7), b >> 7, 32'h320);
		aluCase(encI(opAddiu, 1, 3, 16'h8765), a + 32'hffff_8765, 32'h324);  // negative imm
		aluCase(encI(opAndi, 1, 3, 16'h8765), a & 32'h0000_8765, 32'h328);
		aluCase(encI(opOri, 1, 3, 16'h8765), a | 32'h0000_8765, 32'h32c);
		aluCase(encI(opSlti, 1, 3, 16'hfff0), ($signed(a) < -16) ? 32'd1 : 32'd0, 32'h330);
		aluCase(encI(opLui, 0, 3, 16'h9abc), 32'h9abc_0000, 32'h334);
		// sb at each lane of its own word, sh at both halves
		for (int k = 0; k < 4; k++)
		begin
			w = 32'h208 + 5 * k;
			emitInstr(encI(opSb, 0, 1, w[15:0]));
			expectStore(3, w, 4'b0001 << k, tWord'(a[7:0]) << (8 * k));
		end
		emitInstr(encI(opSh, 0, 2, 16'h0218));
		expectStore(3, 32'h218, 4'b0011, {16'b0, b[15:0]});
		emitInstr(encI(opSh, 0, 2, 16'h021e));
		expectStore(3, 32'h21e, 4'b1100, {b[15:0], 16'b0});
		// sub-word loads, stored back as words
		for (int k = 0; k < 4; k++)
		begin
			bt = a[8*k +: 8];
			loadCase(opLb, 32'h200 + k, {{24{bt[7]}}, bt}, 32'h340 + 8 * k);
			loadCase(opLbu, 32'h200 + k, {24'b0, bt}, 32'h344 + 8 * k);
		end
		for (int h = 0; h < 2; h++)
		begin
			hf = b[16*h +: 16];
			loadCase(opLh, 32'h204 + 2 * h, {{16{hf[15]}}, hf}, 32'h360 + 8 * h);
			loadCase(opLhu, 32'h204 + 2 * h, {16'b0, hf}, 32'h364 + 8 * h);
		end
		// control flow, markers at 0x380 up, wrong paths at 0x3a0 up
		emitInstr(encI(opAddiu, 0, 5, 16'h0011));
		emitInstr(encI(opBeq, 1, 1, 16'h0001));      // taken
		emitInstr(encI(opSw, 0, 5, 16'h03a0));
		storeReg(5, 32'h380, 5, 32'h11);
		emitInstr(encI(opBeq, 1, 2, 16'h0001));      // not taken
		storeReg(5, 32'h384, 5, 32'h11);
		emitInstr(encI(opBne, 1, 1, 16'h0001));      // not taken
		storeReg(5, 32'h388, 5, 32'h11);
		emitInstr(encI(opBne, 1, 2, 16'h0001));      // taken
		emitInstr(encI(opSw, 0, 5, 16'h03a4));
		storeReg(5, 32'h38c, 5, 32'h11);
		emitInstr(encJ(opJ, emitAddr + 8));          // skip one
		emitInstr(encI(opSw, 0, 5, 16'h03a8));
		jalAddr = emitAddr;
		emitInstr(encJ(opJal, subAddr));
		w = emitAddr;
		emitAddr = subAddr;                          // subroutine body
		storeReg(5, 32'h39c, 5, 32'h11);
		emitInstr(encR(fcJr, 31, 0, 0, 0));
		emitAddr = w;
		storeReg(5, 32'h390, 5, 32'h11);
		storeReg(31, 32'h394, 5, jalAddr + 4);       // link value
		emitInstr(32'hfc63_1234);                    // opcode 0x3f, not decoded
		storeReg(5, 32'h398, 5, 32'h11);
		// r0 stays zero
		emitInstr(encI(opAddiu, 0, 0, 16'h0055));
		emitInstr(encR(fcAddu, 1, 2, 0, 0));
		storeReg(0, 32'h3b0, 6, 32'h0);
		haltAddr = emitAddr;
		emitInstr(encI(opBeq, 0, 0, 16'hffff));      // spin here
	endtask

	task automatic noteError(int test);
		errCount[test]++;
		totalErrors++;
	endtask

	task automatic reportTest(int test);
		if (!reported[test])
		begin
			reported[test] = 1'b1;
			if (errCount[test] == 0)
			begin
				$display("test %0d %s: ok", test, testName[test]);
				passCount++;
			end
			else
			begin
				$display("test %0d %s: FAILED with %0d errors", test, testName[test],
					errCount[test]);
				failCount++;
			end
		end
	endtask

	// one store on the bus against the head of the queue
	task automatic checkStore(tWord addr, tByteEn be, tWord word);
		tExpect head;
		assert (expectQ.size() != 0)
		else
		begin
			$display("** Error: %0t ns: stray store of %h to %h", $time, word, addr);
			totalErrors++;
		end
		if (expectQ.size() != 0)
		begin
			head = expectQ[0];
			assert (addr[31:2] == head.addr[31:2])
			else
			begin
				$display("** Error: %0t ns: store to %h, expected one to %h", $time, addr,
					head.addr);
				noteError(head.test);
			end
			if (addr[31:2] == head.addr[31:2])
			begin
				void'(expectQ.pop_front());
				assert (be == head.be && word == head.data)
				else
				begin
					$display("** Error: %0t ns: store to %h gave %h be %b, expected %h be %b",
						$time, addr, word, be, head.data, head.be);
					noteError(head.test);
				end
				if (expectQ.size() == 0 || expectQ[0].test != head.test)
					reportTest(head.test);
			end
		end
	endtask

	// bus checks and memory write port
	always @(posedge iCLK)
	begin
		tWord oldWord, newWord;
		if (iRST)
		begin
			assert (!memReq.we && !memReq.re)
			else
			begin
				$display("** Error: %0t ns: bus strobe high during reset", $time);
				noteError(1);
			end
		end
		else
		begin
			if (!bootChecked && memReq.re)
			begin
				assert (memReq.addr == bootAddr && pc == bootAddr)
				else
				begin
					$display("** Error: %0t ns: first fetch at %h with pc %h", $time,
						memReq.addr, pc);
					noteError(1);
				end
				bootChecked = 1'b1;
				reportTest(1);
			end
			if (memReq.we)
			begin
				oldWord = mem[memReq.addr[9:2]];
				for (int i = 0; i < 4; i++)
					newWord[8*i +: 8] = memReq.byteEn[i] ? memReq.wdata[8*i +: 8]
						: oldWord[8*i +: 8];  // untouched lanes keep old bytes
				mem[memReq.addr[9:2]] <= newWord;
				checkStore(memReq.addr, memReq.byteEn, newWord);
			end
		end
	end

	initial
	begin
		tExpect left;
		iRST = 1'b1;
		testName[1] = "reset and boot fetch";
		testName[2] = "alu results";
		testName[3] = "sub-word stores";
		testName[4] = "sub-word loads";
		testName[5] = "control flow";
		testName[6] = "register zero";
		buildProgram();
		repeat (2) @(posedge iCLK);
		iRST <= 1'b0;
		@(posedge iCLK);
		while (!(memReq.re && memReq.addr == haltAddr))
			@(posedge iCLK);
		repeat (6) @(posedge iCLK);  // a few spins to catch late stores
		while (expectQ.size() != 0)
		begin
			left = expectQ.pop_front();
			$display("test %0d: the store to %h never happened", left.test, left.addr);
			noteError(left.test);
		end
		for (int i = 1; i <= 6; i++)
			reportTest(i);
		$display("summary: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0 && totalErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// watchdog, five cycles per instruction at most plus margin
	initial
	begin
		#1;
		#((instrCount * 5 + 100) * 10);
		$display("timeout: the core never reached the halt loop");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hdl/mipsPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/memLane.sv
hdl/dataPath.sv
hdl/controlFsm.sv
hdl/multiCycleCore.sv
bench/coreTb.sv

/* Bender.yml */
package:
  name: multi_cycle_core

sources:
  - hdl/mipsPkg.sv
  - hdl/regFile.sv
  - hdl/aluUnit.sv
  - hdl/memLane.sv
  - hdl/dataPath.sv
  - hdl/controlFsm.sv
  - hdl/multiCycleCore.sv
  - target: simulation
    files:
      - bench/coreTb.sv
